/* verilog.f */
rtl/anim_pkg.sv
rtl/button_debouncer.sv
rtl/animation_selector.sv
rtl/speed_control.sv
rtl/frame_timer.sv
rtl/segment_animator.sv
rtl/seven_segment_player.sv
bench/seven_segment_player_tb.sv

/* Makefile */
SIM_TOOL   ?= verilator
TOP        ?= seven_segment_player_tb
RTL_TOP    ?= seven_segment_player
FILE_LIST  ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM_TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(SIM_TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/seven_segment_player_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module seven_segment_player_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int DEBOUNCE_LEN  = 4;
    localparam int TICK_DIV      = 3;
    localparam int PERIOD_LO     = 1;
    localparam int PERIOD_HI     = 20;
    localparam int PERIOD_INIT   = 10;
    localparam int BIT_NEXT      = 3;     // Bit positions inside buttons_t
    localparam int BIT_PREV      = 2;
    localparam int BIT_FASTER    = 1;
    localparam int BIT_SLOWER    = 0;
    localparam int ANIM_PRESSES  = 30;
    localparam int GLITCHES      = 20;
    localparam int CLAMP_PRESSES = 24;
    localparam int MIX_PRESSES   = 10;
    localparam int TIMED_STEPS   = 20;
    localparam int MAX_HOLD      = 8;
    localparam int MAX_GAP       = 8;

    // Worst case length of every test, plus slack
    localparam int WATCHDOG_CYCLES = 4 + 2 * (6 + 3) + ANIM_PRESSES * (MAX_HOLD + MAX_GAP)
        + GLITCHES * 7 + 16 + (2 * CLAMP_PRESSES + MIX_PRESSES) * (MAX_HOLD + MAX_GAP)
        + (TIMED_STEPS + 2) * TICK_DIV * PERIOD_HI
        + PERIOD_HI * 6 + 64 * (5 + 17 * TICK_DIV) + 1000;

    // Digits 0 to F, a in bit 0
    localparam logic [6:0] DIGIT_SEGMENTS [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic                    clk = 1'b0;
    logic                    reset;
    anim_pkg::buttons_t      buttons;
    anim_pkg::segments_t     segments;
    anim_pkg::anim_index_t   anim_index;
    anim_pkg::step_t         step;
    anim_pkg::period_level_t period_level;

    logic [31:0] lfsr = 32'h570c_b88c;    // Random source state
    string       test_name;
    int          test_errors;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    int          m_idx;                   // Reference model state
    int          m_last_idx;
    int          m_period;
    int          m_step;
    int          m_elapsed;               // Cycles into the current step
    logic [3:0]  m_press;                 // Predicted press pulses
    logic [3:0]  m_fired;                 // Press already given for this hold
    int          m_run [4];               // Consecutive high samples

    always #(CLK_PERIOD / 2) clk = ~clk;

    seven_segment_player #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN),
        .TICK_DIV     (TICK_DIV)
    ) seven_segment_player_inst (
        .clk          (clk),
        .reset        (reset),
        .buttons      (buttons),
        .segments     (segments),
        .anim_index   (anim_index),
        .step         (step),
        .period_level (period_level)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);   // One step per bit
        end
    endtask

    function automatic int family_limit(input int family);
        case (family)
            0:       return 15;
            1:       return 5;
            2:       return 6;
            default: return 1;
        endcase
    endfunction

    function automatic logic [6:0] expect_segments(input logic [5:0] idx, input logic [4:0] st);
        int         family;
        int         variant;
        int         s;
        logic [6:0] seg;
        family  = int'(idx[5:4]);
        variant = int'(idx[3:0]);
        s       = int'(st);
        seg     = '0;
        case (family)
            0: seg = DIGIT_SEGMENTS[(s + variant) % 16];
            1: seg[idx[0] ? 5 - s : s] = 1'b1;      // Single lit segment
            2: begin
                for (int k = 0; k < s; k++) begin
                    seg[idx[0] ? 5 - k : k] = 1'b1;  // Fill from a, or from f
                end
            end
            default: seg = (s == 0) ? DIGIT_SEGMENTS[variant] : 7'h00;
        endcase
        return seg;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Error %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string message);
        assert (cond) else begin
            $display("Test %s went wrong: %s", test_name, message);
            test_errors++;
        end
    endtask

    task automatic reset_model();
        m_idx      = 0;
        m_last_idx = 0;
        m_period   = PERIOD_INIT;
        m_step     = 0;
        m_elapsed  = 0;
        m_press    = '0;
        m_fired    = '0;
        for (int i = 0; i < 4; i++) begin
            m_run[i] = 0;
        end
    endtask

    // One clock edge of the model, all from the values before the edge
    task automatic update_model(input anim_pkg::buttons_t drive);
        logic [3:0] raw;
        int         new_idx;
        int         new_period;
        int         limit;
        raw        = drive;
        new_idx    = m_idx;
        new_period = m_period;
        if (m_press[BIT_NEXT])
            new_idx = (m_idx + 1) % 64;
        else if (m_press[BIT_PREV])
            new_idx = (m_idx + 63) % 64;
        if (m_press[BIT_FASTER])
            new_period = (m_period > PERIOD_LO) ? m_period - 1 : PERIOD_LO;
        else if (m_press[BIT_SLOWER])
            new_period = (m_period < PERIOD_HI) ? m_period + 1 : PERIOD_HI;
        limit = family_limit(m_idx / 16);
        if (m_idx != m_last_idx) begin
            m_elapsed = 0;                 // New animation restarts at step 0
            m_step    = 0;
        end else if (m_elapsed + 1 >= TICK_DIV * m_period) begin
            m_elapsed = 0;
            m_step    = (m_step >= limit) ? 0 : m_step + 1;
        end else begin
            m_elapsed++;
        end
        m_last_idx = m_idx;
        for (int i = 0; i < 4; i++) begin
            m_press[i] = 1'b0;
            if (!raw[i]) begin
                m_run[i]   = 0;            // Release rearms
                m_fired[i] = 1'b0;
            end else if (!m_fired[i]) begin
                m_run[i]++;
                if (m_run[i] == DEBOUNCE_LEN) begin
                    m_press[i] = 1'b1;
                    m_fired[i] = 1'b1;
                end
            end
        end
        m_idx    = new_idx;
        m_period = new_period;
    endtask

    task automatic compare_outputs();
        int limit;
        check_value("anim_index", m_idx, int'(anim_index));
        check_value("period_level", m_period, int'(period_level));
        check_value("step", m_step, int'(step));
        limit = family_limit(int'(anim_index.family));
        if (int'(step) <= limit)           // Old step lingers one cycle after a switch
            check_value("segments", int'(expect_segments(anim_index, step)), int'(segments));
    endtask

    // Drive just after an edge, sample just after the next one
    task automatic run_cycle(input anim_pkg::buttons_t drive);
        buttons = drive;
        @(posedge clk);
        #1;
        update_model(drive);
        compare_outputs();
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) run_cycle('0);
    endtask

    task automatic hold_button(input int bit_pos, input int hold, input int gap);
        logic [3:0] level;
        level          = '0;
        level[bit_pos] = 1'b1;
        repeat (hold) run_cycle(anim_pkg::buttons_t'(level));
        repeat (gap) run_cycle('0);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s ok", test_name);
        end else begin
            $display("Test %s failed with %0d errors", test_name, test_errors);
            tests_failed++;
            total_errors += test_errors;
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int         value;
        int         which;
        int         hold;
        int         gap;
        int         before_idx;
        int         before_period;
        int         prev_step;
        int         run_len;
        int         changes;
        int         wraps;
        int         start_idx;
        logic [7:0] seen;                 // Family and reverse pairs visited

        reset   = 1'b1;
        buttons = '0;
        reset_model();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("reset_state");
        check_value("anim_index", 0, int'(anim_index));
        check_value("step", 0, int'(step));
        check_value("period_level", PERIOD_INIT, int'(period_level));
        check_value("segments", int'(DIGIT_SEGMENTS[0]), int'(segments));
        idle(2);
        finish_test();

        start_test("anim_stepping");
        hold_button(BIT_PREV, 6, 3);
        check_value("wrap below 0", 63, int'(anim_index));
        hold_button(BIT_NEXT, 6, 3);
        check_value("wrap above 63", 0, int'(anim_index));
        for (int i = 0; i < ANIM_PRESSES; i++) begin
            draw(1, value);
            which = (value != 0) ? BIT_NEXT : BIT_PREV;
            draw(3, hold);
            draw(3, gap);
            hold_button(which, hold + 1, gap + 1);   // Short holds are glitches
        end
        finish_test();

        start_test("debounce");
        before_idx    = m_idx;
        before_period = m_period;
        for (int i = 0; i < GLITCHES; i++) begin
            draw(2, which);
            draw(2, hold);
            draw(2, gap);
            hold_button(which, 1 + hold % 3, gap + 1);
        end
        check_value("anim_index after glitches", before_idx, int'(anim_index));
        check_value("period after glitches", before_period, int'(period_level));
        hold_button(BIT_NEXT, 12, 4);
        check_value("anim_index after long hold", (before_idx + 1) % 64, int'(anim_index));
        finish_test();

        start_test("period_clamp");
        for (int i = 0; i < CLAMP_PRESSES; i++) begin
            hold_button(BIT_FASTER, 4, 2);
            check_true(int'(period_level) >= PERIOD_LO, "period_level fell below 1");
        end
        check_value("period at lower clamp", PERIOD_LO, int'(period_level));
        for (int i = 0; i < CLAMP_PRESSES; i++) begin
            hold_button(BIT_SLOWER, 4, 2);
            check_true(int'(period_level) <= PERIOD_HI, "period_level rose above 20");
        end
        check_value("period at upper clamp", PERIOD_HI, int'(period_level));
        for (int i = 0; i < MIX_PRESSES; i++) begin
            draw(1, value);
            which = (value != 0) ? BIT_FASTER : BIT_SLOWER;
            draw(2, hold);
            hold_button(which, hold + 4, 2);
        end
        finish_test();

        start_test("frame_timing");
        prev_step = int'(step);
        run_len   = 0;
        changes   = 0;
        wraps     = 0;
        while (changes <= TIMED_STEPS) begin
            run_cycle('0);
            run_len++;
            if (int'(step) != prev_step) begin
                if (changes > 0)          // First run started mid step
                    check_value("step length", m_period * TICK_DIV, run_len);
                if (int'(step) == 0) begin
                    check_value("step before wrap", family_limit(m_idx / 16), prev_step);
                    wraps++;
                end else begin
                    check_value("next step", prev_step + 1, int'(step));
                end
                changes++;
                run_len   = 0;
                prev_step = int'(step);
            end
        end
        check_true(wraps > 0, "step never wrapped during the timing run");
        finish_test();

        start_test("segment_sweep");
        for (int i = 0; i < PERIOD_HI && int'(period_level) > PERIOD_LO; i++) begin
            hold_button(BIT_FASTER, 4, 2);  // Shortest frames keep the sweep quick
        end
        start_idx = m_idx;
        seen      = '0;
        for (int i = 0; i < 64; i++) begin
            hold_button(BIT_NEXT, 4, 1);
            seen[int'(anim_index.family) * 2 + int'(anim_index.variant[0])] = 1'b1;
            idle((family_limit(int'(anim_index.family)) + 2) * TICK_DIV * int'(period_level));
        end
        check_value("index after full sweep", start_idx, int'(anim_index));
        check_true(seen == 8'hFF, "sweep missed a family or a reverse setting");
        finish_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/seven_segment_player.sv */
`timescale 1ns/1ps
`default_nettype none

module seven_segment_player #(
    parameter int DEBOUNCE_LEN = 512,     // Stable cycles per button press
    parameter int TICK_DIV     = 500000   // Clock cycles per period unit
) (
    input  logic                    clk,
    input  logic                    reset,
    input  anim_pkg::buttons_t      buttons,       // Raw button levels
    output anim_pkg::segments_t     segments,
    output anim_pkg::anim_index_t   anim_index,
    output anim_pkg::step_t         step,
    output anim_pkg::period_level_t period_level
);

    anim_pkg::buttons_t press;            // One cycle pulses per press
    anim_pkg::step_t    step_limit;       // Fed back from the animator

    button_debouncer #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) next_debouncer_inst (
        .clk   (clk),
        .reset (reset),
        .raw   (buttons.next_anim),
        .press (press.next_anim)
    );

    button_debouncer #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) prev_debouncer_inst (
        .clk   (clk),
        .reset (reset),
        .raw   (buttons.prev_anim),
        .press (press.prev_anim)
    );

    button_debouncer #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) faster_debouncer_inst (
        .clk   (clk),
        .reset (reset),
        .raw   (buttons.faster),
        .press (press.faster)
    );

    button_debouncer #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) slower_debouncer_inst (
        .clk   (clk),
        .reset (reset),
        .raw   (buttons.slower),
        .press (press.slower)
    );

    animation_selector animation_selector_inst (
        .clk        (clk),
        .reset      (reset),
        .next_anim  (press.next_anim),
        .prev_anim  (press.prev_anim),
        .anim_index (anim_index)
    );

    speed_control speed_control_inst (
        .clk          (clk),
        .reset        (reset),
        .faster       (press.faster),
        .slower       (press.slower),
        .period_level (period_level)
    );

    frame_timer #(.TICK_DIV(TICK_DIV)) frame_timer_inst (
        .clk          (clk),
        .reset        (reset),
        .anim_index   (anim_index),
        .period_level (period_level),
        .step_limit   (step_limit),
        .step         (step)
    );

    segment_animator segment_animator_inst (
        .anim_index (anim_index),
        .step       (step),
        .segments   (segments),
        .step_limit (step_limit)
    );

endmodule

`default_nettype wire

/* rtl/segment_animator.sv */
`timescale 1ns/1ps
`default_nettype none

module segment_animator (
    input  anim_pkg::anim_index_t anim_index,
    input  anim_pkg::step_t       step,
    output anim_pkg::segments_t   segments,
    output anim_pkg::step_t       step_limit   // Last step of this family
);

    localparam logic [6:0] RING = 7'h3F;  // Segments a to f, no g

    logic       reverse;                  // Variant bit 0 flips direction
    logic [3:0] hex_value;                // Digit for the hex family
    logic [2:0] spin_pos;                 // Lit segment for the spin family
    logic [2:0] fill_len;                 // Lit segments for the fill family
    logic [6:0] fill_fwd;
    logic [6:0] fill_rev;

    assign reverse   = anim_index.variant[0];
    assign hex_value = step[3:0] + anim_index.variant;   // Wraps modulo 16
    assign spin_pos  = reverse ? (3'd5 - step[2:0]) : step[2:0];
    assign fill_len  = (step > 5'd6) ? 3'd6 : step[2:0];  // Saturate out of range steps

    // Forward fill grows from a, reverse fill grows from f
    assign fill_fwd = ~(7'h7F << fill_len) & RING;
    assign fill_rev = (RING << (3'd6 - fill_len)) & RING;

    always_comb begin
        case (anim_index.family)
            anim_pkg::FAMILY_HEX: begin
                segments   = anim_pkg::hex_glyph(hex_value);
                step_limit = anim_pkg::LIMIT_HEX;
            end
            anim_pkg::FAMILY_SPIN: begin
                segments   = (7'd1 << spin_pos) & RING;  // Blank if position is off ring
                step_limit = anim_pkg::LIMIT_SPIN;
            end
            anim_pkg::FAMILY_FILL: begin
                segments   = reverse ? fill_rev : fill_fwd;
                step_limit = anim_pkg::LIMIT_FILL;
            end
            anim_pkg::FAMILY_BLINK: begin
                if (step == '0)
                    segments = anim_pkg::hex_glyph(anim_index.variant);
                else
                    segments = '0;        // Off phase
                step_limit = anim_pkg::LIMIT_BLINK;
            end
            default: begin
                segments   = '0;
                step_limit = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/frame_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
    parameter int TICK_DIV = 500000       // Clock cycles per period unit
) (
    input  logic                    clk,
    input  logic                    reset,
    input  anim_pkg::anim_index_t   anim_index,
    input  anim_pkg::period_level_t period_level,
    input  anim_pkg::step_t         step_limit,   // Last step of current animation
    output anim_pkg::step_t         step
);

    localparam int PRE_W = $clog2(TICK_DIV + 1);

    logic [PRE_W-1:0]        prescale;    // Cycles within one unit
    anim_pkg::period_level_t units;       // Whole units done in this step
    anim_pkg::anim_index_t   last_anim;   // Index seen on the previous cycle
    logic                    tick;
    logic                    anim_changed;
    logic                    step_done;

    assign tick         = (prescale == PRE_W'(TICK_DIV - 1));
    assign anim_changed = (anim_index != last_anim);

    // Normal end on the last tick, early end if the period just got shorter
    assign step_done = (units >= period_level) ||
                       (tick && ({1'b0, units} + 6'd1 >= {1'b0, period_level}));

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale  <= '0;
            units     <= '0;
            step      <= '0;
            last_anim <= '0;
        end else begin
            last_anim <= anim_index;
            if (anim_changed) begin
                prescale <= '0;           // Restart on new animation
                units    <= '0;
                step     <= '0;
            end else if (step_done) begin
                prescale <= '0;
                units    <= '0;
                if (step >= step_limit)
                    step <= '0;           // Wrap after last step
                else
                    step <= step + 5'd1;
            end else if (tick) begin
                prescale <= '0;
                units    <= units + 5'd1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    // Step stays in range, except the cycle the animation switches
    assert property (@(posedge clk) disable iff (reset)
        !anim_changed |-> step <= step_limit);

endmodule

`default_nettype wire

/* rtl/speed_control.sv */
`timescale 1ns/1ps
`default_nettype none

module speed_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    faster,       // Press pulse, wins over slower
    input  logic                    slower,       // Press pulse
    output anim_pkg::period_level_t period_level  // Frame period in units
);

    logic at_min;
    logic at_max;

    assign at_min = (period_level <= anim_pkg::PERIOD_MIN);
    assign at_max = (period_level >= anim_pkg::PERIOD_MAX);

    always_ff @(posedge clk) begin
        if (reset) begin
            period_level <= anim_pkg::PERIOD_RESET;
        end else if (faster) begin
            if (!at_min)
                period_level <= period_level - 5'd1;  // Shorter frame
        end else if (slower) begin
            if (!at_max)
                period_level <= period_level + 5'd1;  // Longer frame
        end
    end

    // Clamp holds across any press sequence
    assert property (@(posedge clk) disable iff (reset)
        period_level >= anim_pkg::PERIOD_MIN && period_level <= anim_pkg::PERIOD_MAX);

endmodule

`default_nettype wire

/* rtl/animation_selector.sv */
`timescale 1ns/1ps
`default_nettype none

module animation_selector (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  next_anim,   // Press pulse, wins over prev
    input  logic                  prev_anim,   // Press pulse
    output anim_pkg::anim_index_t anim_index
);

    localparam logic [5:0] LAST_INDEX = 6'(anim_pkg::ANIM_COUNT - 1);

    logic [5:0] index;                    // Flat animation number

    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
        end else if (next_anim) begin
            if (index == LAST_INDEX)
                index <= '0;              // Wrap to first
            else
                index <= index + 6'd1;
        end else if (prev_anim) begin
            if (index == '0)
                index <= LAST_INDEX;      // Wrap to last
            else
                index <= index - 6'd1;
        end
    end

    // Family in the high bits, variant in the low bits
    assign anim_index = anim_pkg::anim_index_t'(index);

endmodule

`default_nettype wire

/* rtl/button_debouncer.sv */
`timescale 1ns/1ps
`default_nettype none

module button_debouncer #(
    parameter int DEBOUNCE_LEN = 512      // Stable high cycles before a press
) (
    input  logic clk,
    input  logic reset,
    input  logic raw,                     // Bouncing button level
    output logic press                    // One cycle per stable press
);

    localparam int CNT_W = $clog2(DEBOUNCE_LEN + 1);

    logic [CNT_W-1:0] count;              // Consecutive high cycles so far
    logic             armed;              // Cleared once this press has fired

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            armed <= 1'b1;
            press <= 1'b0;
        end else begin
            press <= 1'b0;                // Pulse by default
            if (!raw) begin
                count <= '0;              // Any low sample restarts the count
                armed <= 1'b1;            // Release rearms
            end else if (armed) begin
                if (count == CNT_W'(DEBOUNCE_LEN - 1)) begin
                    press <= 1'b1;
                    armed <= 1'b0;        // Wait for release
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // A held button never repeats
    assert property (@(posedge clk) disable iff (reset) press |=> !press);

endmodule

`default_nettype wire

/* rtl/anim_pkg.sv */
`default_nettype none

package anim_pkg;

    // One bit per push button, also used for the press pulses
    typedef struct packed {
        logic next_anim;                  // Step to next animation
        logic prev_anim;                  // Step to previous animation
        logic faster;                     // Shorter frame period
        logic slower;                     // Longer frame period
    } buttons_t;

    // Animation index split into family and variant
    typedef struct packed {
        logic [1:0] family;               // High part picks the pattern kind
        logic [3:0] variant;              // Low part tweaks the pattern
    } anim_index_t;

    typedef logic [4:0] step_t;           // Step within an animation
    typedef logic [4:0] period_level_t;   // Frame period in units
    typedef logic [6:0] segments_t;       // a is bit 0, g is bit 6, active high

    localparam int ANIM_COUNT = 64;       // Animations reachable by the buttons

    localparam period_level_t PERIOD_MIN   = 5'd1;
    localparam period_level_t PERIOD_MAX   = 5'd20;
    localparam period_level_t PERIOD_RESET = 5'd10;

    localparam logic [1:0] FAMILY_HEX   = 2'd0;  // Counting hex digits
    localparam logic [1:0] FAMILY_SPIN  = 2'd1;  // Single rotating segment
    localparam logic [1:0] FAMILY_FILL  = 2'd2;  // Ring filling up
    localparam logic [1:0] FAMILY_BLINK = 2'd3;  // Digit on, then blank

    localparam step_t LIMIT_HEX   = 5'd15;       // Last step of each family
    localparam step_t LIMIT_SPIN  = 5'd5;
    localparam step_t LIMIT_FILL  = 5'd6;
    localparam step_t LIMIT_BLINK = 5'd1;

    // Standard glyphs 0 to F
    function automatic segments_t hex_glyph(input logic [3:0] value);
        case (value)
            4'h0:    return 7'h3F;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5B;
            4'h3:    return 7'h4F;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6D;
            4'h6:    return 7'h7D;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7F;
            4'h9:    return 7'h6F;
            4'hA:    return 7'h77;
            4'hB:    return 7'h7C;    // Lower case b
            4'hC:    return 7'h39;
            4'hD:    return 7'h5E;    // Lower case d
            4'hE:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

endpackage

`default_nettype wire
